// File: verilog/refill_pkg.sv
`default_nettype none

package refill_pkg;

    // Address and line geometry
    localparam int ADDR_SIZE = 32;
    localparam int LANE_SIZE = 128;
    localparam int BYTE_SIZE = 4;

    // Cache associativity
    localparam int NUM_WAYS     = 4;
    localparam int WAY_IDX_SIZE = 2;

    // One bit per pair of ways
    localparam int LRU_STATE_SIZE = NUM_WAYS * (NUM_WAYS - 1) / 2;

    // Main memory and write buffer
    localparam int MEM_LINES_LOG2 = 8;
    localparam int MEM_LATENCY    = 4;
    localparam int WB_DEPTH       = 4;

    typedef logic [ADDR_SIZE-1:0]           addr_t;
    typedef logic [ADDR_SIZE-BYTE_SIZE-1:0] line_addr_t;
    typedef logic [LANE_SIZE-1:0]           lane_t;
    typedef logic [WAY_IDX_SIZE-1:0]        way_idx_t;
    typedef logic [LRU_STATE_SIZE-1:0]      lru_state_t;

    typedef enum logic [2:0] {
        ARB_IDLE,
        DC_REQ,
        DC_WAIT,
        IC_REQ,
        IC_WAIT
    } refill_state_e;

endpackage : refill_pkg

`default_nettype wire

// File: verilog/lru_tracker.sv
`default_nettype none

module lru_tracker (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 touch_i,
    input  wire refill_pkg::way_idx_t touch_way_i,
    output refill_pkg::way_idx_t      victim_o
);

    // Bit of pair (i, j), i < j, is set when way i is older than way j
    refill_pkg::lru_state_t older_q;
    refill_pkg::lru_state_t older_d;
    logic [refill_pkg::NUM_WAYS-1:0] victim_oh;

    function automatic int pair_idx(input int i, input int j);
        return i * refill_pkg::NUM_WAYS - (i * (i + 1)) / 2 + (j - i - 1);
    endfunction

    // Touched way becomes newer than every other way
    always_comb begin
        older_d = older_q;
        for (int i = 0; i < refill_pkg::NUM_WAYS; i++) begin
            for (int j = i + 1; j < refill_pkg::NUM_WAYS; j++) begin
                if (int'(touch_way_i) == i) begin
                    older_d[pair_idx(i, j)] = 1'b0;
                end else if (int'(touch_way_i) == j) begin
                    older_d[pair_idx(i, j)] = 1'b1;
                end
            end
        end
    end

    // All ones gives the order 0 (oldest) to 3
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            older_q <= '1;
        end else if (touch_i) begin
            older_q <= older_d;
        end
    end

    // Victim is older than all others
    always_comb begin
        for (int k = 0; k < refill_pkg::NUM_WAYS; k++) begin
            victim_oh[k] = 1'b1;
            for (int m = 0; m < refill_pkg::NUM_WAYS; m++) begin
                if (m > k) begin
                    if (!older_q[pair_idx(k, m)]) begin
                        victim_oh[k] = 1'b0;
                    end
                end else if (m < k) begin
                    if (older_q[pair_idx(m, k)]) begin
                        victim_oh[k] = 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        victim_o = '0;
        for (int k = 0; k < refill_pkg::NUM_WAYS; k++) begin
            if (victim_oh[k]) begin
                victim_o = refill_pkg::way_idx_t'(k);
            end
        end
    end

    // Matrix must always describe a total order
    victim_onehot_a : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot(victim_oh));

endmodule : lru_tracker

`default_nettype wire

// File: verilog/refill_arbiter.sv
`default_nettype none

module refill_arbiter (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    // Data cache
    input  wire logic                   dc_access_i,
    input  wire refill_pkg::way_idx_t   dc_hit_way_i,
    input  wire logic                   dc_miss_i,
    input  wire refill_pkg::addr_t      dc_addr_i,
    output logic                        dc_rdy_o,
    output refill_pkg::lane_t           dc_data_o,
    output refill_pkg::way_idx_t        dc_victim_o,
    // Instruction cache
    input  wire logic                   ic_access_i,
    input  wire refill_pkg::way_idx_t   ic_hit_way_i,
    input  wire logic                   ic_miss_i,
    input  wire refill_pkg::addr_t      ic_addr_i,
    output logic                        ic_rdy_o,
    output refill_pkg::lane_t           ic_data_o,
    output refill_pkg::way_idx_t        ic_victim_o,
    // Refill reads towards the write buffer
    output logic                        rd_req_o,
    output refill_pkg::line_addr_t      rd_addr_o,
    input  wire logic                   rd_ready_i,
    // Memory read data
    input  wire logic                   mem_rvalid_i,
    input  wire refill_pkg::lane_t      mem_rdata_i
);

    refill_pkg::refill_state_e state_q;
    refill_pkg::refill_state_e state_d;

    logic                   dc_pend_q;
    logic                   ic_pend_q;
    refill_pkg::line_addr_t dc_line_q;
    refill_pkg::line_addr_t ic_line_q;
    logic                   dc_capture;
    logic                   ic_capture;
    logic                   dc_fill;
    logic                   ic_fill;
    logic                   dc_touch;
    logic                   ic_touch;
    refill_pkg::way_idx_t   dc_touch_way;
    refill_pkg::way_idx_t   ic_touch_way;
    refill_pkg::way_idx_t   dc_victim;
    refill_pkg::way_idx_t   ic_victim;

    // Miss still held during its rdy pulse must not be taken again
    assign dc_capture = dc_miss_i && !dc_pend_q && !dc_rdy_o;
    assign ic_capture = ic_miss_i && !ic_pend_q && !ic_rdy_o;

    assign dc_fill = (state_q == refill_pkg::DC_WAIT) && mem_rvalid_i;
    assign ic_fill = (state_q == refill_pkg::IC_WAIT) && mem_rvalid_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dc_pend_q <= 1'b0;
            ic_pend_q <= 1'b0;
        end else begin
            if (dc_fill) begin
                dc_pend_q <= 1'b0;
            end else if (dc_capture) begin
                dc_pend_q <= 1'b1;
            end
            if (ic_fill) begin
                ic_pend_q <= 1'b0;
            end else if (ic_capture) begin
                ic_pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dc_capture) begin
            dc_line_q <= dc_addr_i[refill_pkg::ADDR_SIZE-1:refill_pkg::BYTE_SIZE];
        end
        if (ic_capture) begin
            ic_line_q <= ic_addr_i[refill_pkg::ADDR_SIZE-1:refill_pkg::BYTE_SIZE];
        end
    end

    // Data cache always wins from idle
    always_comb begin
        state_d   = state_q;
        rd_req_o  = 1'b0;
        rd_addr_o = dc_line_q;
        case (state_q)
            refill_pkg::ARB_IDLE: begin
                if (dc_pend_q) begin
                    state_d = refill_pkg::DC_REQ;
                end else if (ic_pend_q) begin
                    state_d = refill_pkg::IC_REQ;
                end
            end
            refill_pkg::DC_REQ: begin
                if (rd_ready_i) begin
                    rd_req_o = 1'b1;
                    state_d  = refill_pkg::DC_WAIT;
                end
            end
            refill_pkg::DC_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = ic_pend_q ? refill_pkg::IC_REQ : refill_pkg::ARB_IDLE;
                end
            end
            refill_pkg::IC_REQ: begin
                rd_addr_o = ic_line_q;
                if (rd_ready_i) begin
                    rd_req_o = 1'b1;
                    state_d  = refill_pkg::IC_WAIT;
                end
            end
            refill_pkg::IC_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = dc_pend_q ? refill_pkg::DC_REQ : refill_pkg::ARB_IDLE;
                end
            end
            default: begin
                state_d = refill_pkg::ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= refill_pkg::ARB_IDLE;
            dc_rdy_o <= 1'b0;
            ic_rdy_o <= 1'b0;
        end else begin
            state_q  <= state_d;
            dc_rdy_o <= dc_fill;
            ic_rdy_o <= ic_fill;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dc_fill) begin
            dc_data_o   <= mem_rdata_i;
            dc_victim_o <= dc_victim;
        end
        if (ic_fill) begin
            ic_data_o   <= mem_rdata_i;
            ic_victim_o <= ic_victim;
        end
    end

    // Refill beats a hit in the same cycle and drops its touch
    assign dc_touch     = dc_fill || dc_access_i;
    assign dc_touch_way = dc_fill ? dc_victim : dc_hit_way_i;
    assign ic_touch     = ic_fill || ic_access_i;
    assign ic_touch_way = ic_fill ? ic_victim : ic_hit_way_i;

    lru_tracker dc_lru_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .touch_i     (dc_touch),
        .touch_way_i (dc_touch_way),
        .victim_o    (dc_victim)
    );

    lru_tracker ic_lru_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .touch_i     (ic_touch),
        .touch_way_i (ic_touch_way),
        .victim_o    (ic_victim)
    );

    rdy_exclusive_a : assert property (@(posedge clk_i) disable iff (rst_i)
        !(dc_rdy_o && ic_rdy_o));

    rd_req_ready_a : assert property (@(posedge clk_i) disable iff (rst_i)
        rd_req_o |-> rd_ready_i);

endmodule : refill_arbiter

`default_nettype wire

// File: verilog/write_buffer.sv
`default_nettype none

module write_buffer (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    // Writeback channel from the data cache
    input  wire logic                   wb_valid_i,
    input  wire refill_pkg::line_addr_t wb_addr_i,
    input  wire refill_pkg::lane_t      wb_data_i,
    output logic                        wb_ready_o,
    // Refill reads from the arbiter
    input  wire logic                   rd_req_i,
    input  wire refill_pkg::line_addr_t rd_addr_i,
    output logic                        rd_ready_o,
    // Memory port
    output logic                        mem_req_o,
    output logic                        mem_we_o,
    output refill_pkg::line_addr_t      mem_addr_o,
    output refill_pkg::lane_t           mem_wdata_o,
    input  wire logic                   mem_busy_i
);

    refill_pkg::line_addr_t addr_q [refill_pkg::WB_DEPTH];
    refill_pkg::lane_t      data_q [refill_pkg::WB_DEPTH];

    logic [$clog2(refill_pkg::WB_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(refill_pkg::WB_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(refill_pkg::WB_DEPTH):0]   count_q;
    logic                                    push;
    logic                                    pop;

    assign wb_ready_o = (count_q != refill_pkg::WB_DEPTH);
    assign push       = wb_valid_i && wb_ready_o;

    // Drain only on a free memory port
    assign pop = (count_q != '0) && !mem_busy_i && !rd_req_i;

    // Reads pass only once every older write has reached memory
    assign rd_ready_o = (count_q == '0) && !mem_busy_i;

    assign mem_req_o   = rd_req_i || pop;
    assign mem_we_o    = pop;
    assign mem_addr_o  = rd_req_i ? rd_addr_i : addr_q[rd_ptr_q];
    assign mem_wdata_o = data_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[wr_ptr_q] <= wb_addr_i;
            data_q[wr_ptr_q] <= wb_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr_q == refill_pkg::WB_DEPTH - 1) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr_q == refill_pkg::WB_DEPTH - 1) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    no_push_full_a : assert property (@(posedge clk_i) disable iff (rst_i)
        count_q <= refill_pkg::WB_DEPTH);

    // Arbiter must never start a read while memory is still returning one
    no_read_busy_a : assert property (@(posedge clk_i) disable iff (rst_i)
        rd_req_i |-> !mem_busy_i);

endmodule : write_buffer

`default_nettype wire

// File: verilog/lane_memory.sv
`default_nettype none

module lane_memory (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic                   mem_req_i,
    input  wire logic                   mem_we_i,
    input  wire refill_pkg::line_addr_t mem_addr_i,
    input  wire refill_pkg::lane_t      mem_wdata_i,
    output logic                        mem_busy_o,
    output logic                        mem_rvalid_o,
    output refill_pkg::lane_t           mem_rdata_o
);

    refill_pkg::lane_t mem_q [2**refill_pkg::MEM_LINES_LOG2];

    logic [refill_pkg::MEM_LINES_LOG2-1:0]    rd_line_q;
    logic [$clog2(refill_pkg::MEM_LATENCY)-1:0] lat_cnt_q;
    logic                                     rd_accept;

    assign rd_accept  = mem_req_i && !mem_we_i;
    assign mem_busy_o = (lat_cnt_q != '0) || mem_rvalid_o;

    always_ff @(posedge clk_i) begin
        if (mem_req_i && mem_we_i) begin
            mem_q[mem_addr_i[refill_pkg::MEM_LINES_LOG2-1:0]] <= mem_wdata_i;
        end
        if (rd_accept) begin
            rd_line_q <= mem_addr_i[refill_pkg::MEM_LINES_LOG2-1:0];
        end
        // Data lands in the register at the same edge as rvalid
        if (lat_cnt_q == 1) begin
            mem_rdata_o <= mem_q[rd_line_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lat_cnt_q    <= '0;
            mem_rvalid_o <= 1'b0;
        end else begin
            mem_rvalid_o <= (lat_cnt_q == 1);
            if (rd_accept) begin
                lat_cnt_q <= ($clog2(refill_pkg::MEM_LATENCY))'(refill_pkg::MEM_LATENCY - 1);
            end else if (lat_cnt_q != '0) begin
                lat_cnt_q <= lat_cnt_q - 1'b1;
            end
        end
    end

    no_req_busy_a : assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_i |-> !mem_busy_o);

endmodule : lane_memory

`default_nettype wire

// File: verilog/refill_top.sv
`default_nettype none

module refill_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    // Data cache
    input  wire logic                   dc_access_i,
    input  wire refill_pkg::way_idx_t   dc_hit_way_i,
    input  wire logic                   dc_miss_i,
    input  wire refill_pkg::addr_t      dc_addr_i,
    output logic                        dc_rdy_o,
    output refill_pkg::lane_t           dc_data_o,
    output refill_pkg::way_idx_t        dc_victim_o,
    // Data cache writebacks
    input  wire logic                   wb_valid_i,
    input  wire refill_pkg::line_addr_t wb_addr_i,
    input  wire refill_pkg::lane_t      wb_data_i,
    output logic                        wb_ready_o,
    // Instruction cache
    input  wire logic                   ic_access_i,
    input  wire refill_pkg::way_idx_t   ic_hit_way_i,
    input  wire logic                   ic_miss_i,
    input  wire refill_pkg::addr_t      ic_addr_i,
    output logic                        ic_rdy_o,
    output refill_pkg::lane_t           ic_data_o,
    output refill_pkg::way_idx_t        ic_victim_o
);

    logic                   rd_req;
    refill_pkg::line_addr_t rd_addr;
    logic                   rd_ready;
    logic                   mem_req;
    logic                   mem_we;
    refill_pkg::line_addr_t mem_addr;
    refill_pkg::lane_t      mem_wdata;
    logic                   mem_busy;
    logic                   mem_rvalid;
    refill_pkg::lane_t      mem_rdata;

    refill_arbiter arbiter_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dc_access_i  (dc_access_i),
        .dc_hit_way_i (dc_hit_way_i),
        .dc_miss_i    (dc_miss_i),
        .dc_addr_i    (dc_addr_i),
        .dc_rdy_o     (dc_rdy_o),
        .dc_data_o    (dc_data_o),
        .dc_victim_o  (dc_victim_o),
        .ic_access_i  (ic_access_i),
        .ic_hit_way_i (ic_hit_way_i),
        .ic_miss_i    (ic_miss_i),
        .ic_addr_i    (ic_addr_i),
        .ic_rdy_o     (ic_rdy_o),
        .ic_data_o    (ic_data_o),
        .ic_victim_o  (ic_victim_o),
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .rd_ready_i   (rd_ready),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    write_buffer write_buffer_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wb_valid_i  (wb_valid_i),
        .wb_addr_i   (wb_addr_i),
        .wb_data_i   (wb_data_i),
        .wb_ready_o  (wb_ready_o),
        .rd_req_i    (rd_req),
        .rd_addr_i   (rd_addr),
        .rd_ready_o  (rd_ready),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_busy_i  (mem_busy)
    );

    lane_memory lane_memory_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_req_i    (mem_req),
        .mem_we_i     (mem_we),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_busy_o   (mem_busy),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata)
    );

endmodule : refill_top

`default_nettype wire

// File: test/tb_refill_top.sv
`default_nettype none

module tb_refill_top;

    localparam int WAIT_LIMIT = 200;
    localparam int SB_LINES   = 2**refill_pkg::MEM_LINES_LOG2;
    localparam int DC         = 0;
    localparam int IC         = 1;

    logic                   clk_i;
    logic                   rst_i;
    logic                   dc_access_i;
    refill_pkg::way_idx_t   dc_hit_way_i;
    logic                   dc_miss_i;
    refill_pkg::addr_t      dc_addr_i;
    logic                   dc_rdy_o;
    refill_pkg::lane_t      dc_data_o;
    refill_pkg::way_idx_t   dc_victim_o;
    logic                   wb_valid_i;
    refill_pkg::line_addr_t wb_addr_i;
    refill_pkg::lane_t      wb_data_i;
    logic                   wb_ready_o;
    logic                   ic_access_i;
    refill_pkg::way_idx_t   ic_hit_way_i;
    logic                   ic_miss_i;
    refill_pkg::addr_t      ic_addr_i;
    logic                   ic_rdy_o;
    refill_pkg::lane_t      ic_data_o;
    refill_pkg::way_idx_t   ic_victim_o;

    // Expected memory contents per decoded line
    refill_pkg::lane_t sb_data [SB_LINES];

    // Last touch time per way with the smallest as LRU victim
    int unsigned lru_stamp [2][refill_pkg::NUM_WAYS];
    int unsigned stamp_next;

    int          errors;
    int          checks;
    int          timeouts;
    logic        wb_stalled;
    time         dc_rdy_time;
    time         ic_rdy_time;
    int unsigned seed_val;

    refill_top refill_top_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dc_access_i  (dc_access_i),
        .dc_hit_way_i (dc_hit_way_i),
        .dc_miss_i    (dc_miss_i),
        .dc_addr_i    (dc_addr_i),
        .dc_rdy_o     (dc_rdy_o),
        .dc_data_o    (dc_data_o),
        .dc_victim_o  (dc_victim_o),
        .wb_valid_i   (wb_valid_i),
        .wb_addr_i    (wb_addr_i),
        .wb_data_i    (wb_data_i),
        .wb_ready_o   (wb_ready_o),
        .ic_access_i  (ic_access_i),
        .ic_hit_way_i (ic_hit_way_i),
        .ic_miss_i    (ic_miss_i),
        .ic_addr_i    (ic_addr_i),
        .ic_rdy_o     (ic_rdy_o),
        .ic_data_o    (ic_data_o),
        .ic_victim_o  (ic_victim_o)
    );

    always #2 clk_i = ~clk_i;

    // Inputs change 1 unit after the rising edge
    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_lane(input string what, input refill_pkg::lane_t got,
                              input refill_pkg::lane_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_way(input string what, input refill_pkg::way_idx_t got,
                             input refill_pkg::way_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got way %0d expected way %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    function automatic refill_pkg::lane_t rand_lane();
        refill_pkg::lane_t v;
        for (int i = 0; i < refill_pkg::LANE_SIZE / 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic refill_pkg::way_idx_t predict_victim(input int cache);
        refill_pkg::way_idx_t way;
        way = '0;
        for (int w = 1; w < refill_pkg::NUM_WAYS; w++) begin
            if (lru_stamp[cache][w] < lru_stamp[cache][way]) begin
                way = refill_pkg::way_idx_t'(w);
            end
        end
        return way;
    endfunction

    task automatic note_touch(input int cache, input refill_pkg::way_idx_t way);
        lru_stamp[cache][way] = stamp_next;
        stamp_next++;
    endtask

    task automatic do_writeback(input refill_pkg::line_addr_t addr,
                                input refill_pkg::lane_t data);
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        wb_valid_i = 1'b1;
        wb_addr_i  = addr;
        wb_data_i  = data;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            if (wb_ready_o) begin
                done = 1'b1;
            end else begin
                wb_stalled = 1'b1;
                n++;
            end
        end
        if (!done) begin
            report_timeout("wb_ready_o");
        end
        step();
        wb_valid_i = 1'b0;
        if (done) begin
            sb_data[addr[refill_pkg::MEM_LINES_LOG2-1:0]] = data;
        end
    endtask

    task automatic do_dc_miss(input refill_pkg::line_addr_t line);
        refill_pkg::way_idx_t exp_victim;
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        dc_miss_i = 1'b1;
        // Byte offset is ignored by the refill path
        dc_addr_i = {line, 4'h4};
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            if (dc_rdy_o) begin
                done = 1'b1;
                dc_rdy_time = $time;
                exp_victim = predict_victim(DC);
                check_lane("dc refill data", dc_data_o,
                           sb_data[line[refill_pkg::MEM_LINES_LOG2-1:0]]);
                check_way("dc victim", dc_victim_o, exp_victim);
                note_touch(DC, exp_victim);
            end else begin
                n++;
            end
        end
        if (!done) begin
            report_timeout("dc_rdy_o");
        end
        step();
        dc_miss_i = 1'b0;
    endtask

    task automatic do_ic_miss(input refill_pkg::line_addr_t line);
        refill_pkg::way_idx_t exp_victim;
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        ic_miss_i = 1'b1;
        ic_addr_i = {line, 4'h8};
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            if (ic_rdy_o) begin
                done = 1'b1;
                ic_rdy_time = $time;
                exp_victim = predict_victim(IC);
                check_lane("ic refill data", ic_data_o,
                           sb_data[line[refill_pkg::MEM_LINES_LOG2-1:0]]);
                check_way("ic victim", ic_victim_o, exp_victim);
                note_touch(IC, exp_victim);
            end else begin
                n++;
            end
        end
        if (!done) begin
            report_timeout("ic_rdy_o");
        end
        step();
        ic_miss_i = 1'b0;
    endtask

    task automatic do_hit(input int cache, input refill_pkg::way_idx_t way);
        if (cache == DC) begin
            dc_access_i  = 1'b1;
            dc_hit_way_i = way;
        end else begin
            ic_access_i  = 1'b1;
            ic_hit_way_i = way;
        end
        step();
        dc_access_i = 1'b0;
        ic_access_i = 1'b0;
        note_touch(cache, way);
    endtask

    task automatic quiet_after_reset();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_i);
            check_bit("dc_rdy_o while idle", dc_rdy_o, 1'b0);
            check_bit("ic_rdy_o while idle", ic_rdy_o, 1'b0);
            check_bit("wb_ready_o while idle", wb_ready_o, 1'b1);
        end
        step();
    endtask

    task automatic writeback_then_refill();
        for (int i = 0; i < 3; i++) begin
            do_writeback(refill_pkg::line_addr_t'('h10 + i), rand_lane());
        end
        for (int i = 0; i < 3; i++) begin
            do_dc_miss(refill_pkg::line_addr_t'('h10 + i));
        end
        // Miss right behind its own writeback
        do_writeback(refill_pkg::line_addr_t'('h13), rand_lane());
        do_dc_miss(refill_pkg::line_addr_t'('h13));
    endtask

    task automatic lru_victim_order();
        for (int i = 0; i < 4; i++) begin
            do_dc_miss(refill_pkg::line_addr_t'('h10 + i));
        end
        do_hit(DC, refill_pkg::way_idx_t'(1));
        do_hit(DC, refill_pkg::way_idx_t'(0));
        do_dc_miss(refill_pkg::line_addr_t'('h11));
    endtask

    task automatic dual_miss_order();
        do_writeback(refill_pkg::line_addr_t'('h20), rand_lane());
        do_writeback(refill_pkg::line_addr_t'('h21), rand_lane());
        dc_rdy_time = 0;
        ic_rdy_time = 0;
        fork
            do_dc_miss(refill_pkg::line_addr_t'('h20));
            do_ic_miss(refill_pkg::line_addr_t'('h21));
        join
        checks++;
        if (!(dc_rdy_time < ic_rdy_time)) begin
            errors++;
            $display("ERROR %0t: dc rdy at %0t did not come before ic rdy at %0t",
                     $time, dc_rdy_time, ic_rdy_time);
        end
    endtask

    task automatic burst_during_refill();
        wb_stalled = 1'b0;
        fork
            do_dc_miss(refill_pkg::line_addr_t'('h20));
            begin
                // Read reaches memory two edges after the miss is raised
                repeat (2) step();
                for (int i = 0; i < 6; i++) begin
                    do_writeback(refill_pkg::line_addr_t'('h30 + i), rand_lane());
                end
            end
        join
        check_bit("wb_ready_o dropped during burst", wb_stalled, 1'b1);
        for (int i = 0; i < 6; i++) begin
            do_dc_miss(refill_pkg::line_addr_t'('h30 + i));
        end
    endtask

    initial begin
        seed_val     = $urandom(32'h1dea3179);
        errors       = 0;
        checks       = 0;
        timeouts     = 0;
        wb_stalled   = 1'b0;
        dc_rdy_time  = 0;
        ic_rdy_time  = 0;
        stamp_next   = refill_pkg::NUM_WAYS;
        for (int c = 0; c < 2; c++) begin
            for (int w = 0; w < refill_pkg::NUM_WAYS; w++) begin
                lru_stamp[c][w] = w;
            end
        end
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        dc_access_i  = 1'b0;
        dc_hit_way_i = '0;
        dc_miss_i    = 1'b0;
        dc_addr_i    = '0;
        wb_valid_i   = 1'b0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        ic_access_i  = 1'b0;
        ic_hit_way_i = '0;
        ic_miss_i    = 1'b0;
        ic_addr_i    = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        quiet_after_reset();
        writeback_then_refill();
        lru_victim_order();
        dual_miss_order();
        burst_during_refill();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_refill_top

`default_nettype wire

// File: project.f
verilog/refill_pkg.sv
verilog/lru_tracker.sv
verilog/refill_arbiter.sv
verilog/write_buffer.sv
verilog/lane_memory.sv
verilog/refill_top.sv
test/tb_refill_top.sv
